// ==== src/pkt_pkg.sv ====
`default_nettype none

package pkt_pkg;

  localparam int sample_w        = 32;
  localparam int cntr_w          = 16;
  localparam int fifo_depth_log2 = 3;
  localparam int reg_addr_w      = 2;

  typedef logic [sample_w-1:0]   sample_t;
  typedef logic [cntr_w-1:0]     pkt_len_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // register map.
  localparam reg_addr_t reg_addr_len   = 2'd0;
  localparam reg_addr_t reg_addr_ctrl  = 2'd1;
  localparam reg_addr_t reg_addr_count = 2'd2;

  // pkt_len is the index of the last beat, so a packet has pkt_len + 1 beats.
  typedef struct packed {
    pkt_len_t pkt_len;
    logic     continuous;
    logic     drain;
  } pkt_cfg_t;

  typedef struct packed {
    logic        en;
    reg_addr_t   addr;
    logic [31:0] data;
  } reg_wr_t;

  typedef struct packed {
    sample_t data;
    logic    last;
  } axis_beat_t;

endpackage

`default_nettype wire

// ==== src/pkt_cfg_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module pkt_cfg_regs
(
  input  wire logic                aclk,
  input  wire logic                aresetn,
  input  wire pkt_pkg::reg_wr_t    reg_wr,
  input  wire pkt_pkg::reg_addr_t  rd_addr,
  output logic [31:0]              rd_data,
  input  wire logic                pkt_done,
  output pkt_pkg::pkt_cfg_t        cfg,
  output logic                     arm
);

  import pkt_pkg::*;

  logic [31:0] pkt_cnt;
  logic [31:0] rd_mux;

  // a write to the length register re-arms the packetizer one cycle later.
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      cfg <= '0;
      arm <= 1'b0;
    end
    else
    begin
      arm <= reg_wr.en && (reg_wr.addr == reg_addr_len);
      if (reg_wr.en)
      begin
        case (reg_wr.addr)
          reg_addr_len:
          begin
            cfg.pkt_len <= reg_wr.data[cntr_w-1:0];
          end
          reg_addr_ctrl:
          begin
            cfg.continuous <= reg_wr.data[0];
            cfg.drain      <= reg_wr.data[1];
          end
          default:
          begin
          end
        endcase
      end
    end
  end

  // the clear by a write wins over a packet that ends in the same cycle.
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      pkt_cnt <= '0;
    end
    else if (reg_wr.en && (reg_wr.addr == reg_addr_count))
    begin
      pkt_cnt <= '0;
    end
    else if (pkt_done)
    begin
      pkt_cnt <= pkt_cnt + 1'b1;
    end
  end

  always_comb
  begin
    rd_mux = '0;
    case (rd_addr)
      reg_addr_len:   rd_mux[cntr_w-1:0] = cfg.pkt_len;
      reg_addr_ctrl:  rd_mux[1:0] = {cfg.drain, cfg.continuous};
      reg_addr_count: rd_mux = pkt_cnt;
      default:        rd_mux = '0;
    endcase
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      rd_data <= '0;
    end
    else
    begin
      rd_data <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// ==== src/axis_sample_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module axis_sample_fifo
(
  input  wire logic              aclk,
  input  wire logic              aresetn,
  input  wire pkt_pkg::sample_t  s_tdata,
  input  wire logic              s_tvalid,
  output logic                   s_tready,
  output pkt_pkg::sample_t       m_tdata,
  output logic                   m_tvalid,
  input  wire logic              m_tready
);

  import pkt_pkg::*;

  sample_t                    mem [2**fifo_depth_log2];
  logic [fifo_depth_log2-1:0] wr_ptr;
  logic [fifo_depth_log2-1:0] rd_ptr;
  logic [fifo_depth_log2:0]   fill;
  logic                       full;
  logic                       push;
  logic                       pop;

  // the fill count reaches exactly the depth when full, so its top bit marks it.
  assign full = fill[fifo_depth_log2];

  // when full, a beat leaving this cycle frees the slot for the incoming one.
  assign s_tready = !full || m_tready;
  assign m_tvalid = (fill != '0);
  assign m_tdata  = mem[rd_ptr];

  assign push = s_tvalid && s_tready;
  assign pop  = m_tvalid && m_tready;

  always_ff @(posedge aclk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= s_tdata;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      fill <= '0;
    end
    else
    begin
      case ({push, pop})
        2'b10:
        begin
          fill <= fill + 1'b1;
        end
        2'b01:
        begin
          fill <= fill - 1'b1;
        end
        default:
        begin
          fill <= fill;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/axis_packetizer.sv ====
`timescale 1ns/100ps
`default_nettype none

module axis_packetizer
(
  input  wire logic               aclk,
  input  wire logic               aresetn,
  input  wire pkt_pkg::pkt_cfg_t  cfg,
  input  wire logic               arm,
  input  wire pkt_pkg::sample_t   s_tdata,
  input  wire logic               s_tvalid,
  output logic                    s_tready,
  output pkt_pkg::axis_beat_t     m_beat,
  output logic                    m_tvalid,
  input  wire logic               m_tready,
  output logic                    pkt_done
);

  import pkt_pkg::*;

  pkt_len_t cntr_reg;
  pkt_len_t cntr_next;
  logic     enbl_reg;
  logic     enbl_next;
  logic     below_len;
  logic     last_beat;
  logic     beat_xfer;

  assign below_len = (cntr_reg < cfg.pkt_len);

  // a counter at or above the length marks the last beat, which also covers
  // a length lowered while a packet is running.
  assign last_beat = enbl_reg && !below_len;

  assign m_tvalid  = enbl_reg && s_tvalid;
  assign beat_xfer = m_tvalid && m_tready;
  assign pkt_done  = beat_xfer && last_beat;

  // while idle the input either stalls or is thrown away.
  assign s_tready = enbl_reg ? m_tready : cfg.drain;

  assign m_beat = '{data: s_tdata, last: last_beat};

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      cntr_reg <= '0;
      enbl_reg <= 1'b0;
    end
    else
    begin
      cntr_reg <= cntr_next;
      enbl_reg <= enbl_next;
    end
  end

  always_comb
  begin
    cntr_next = cntr_reg;
    enbl_next = enbl_reg;

    if (!enbl_reg && below_len)
    begin
      enbl_next = 1'b1;
    end

    if (beat_xfer)
    begin
      if (below_len)
      begin
        cntr_next = cntr_reg + 1'b1;
      end
      else if (cfg.continuous)
      begin
        cntr_next = '0;
      end
      else
      begin
        // in one-shot mode the counter holds at the length so the enable stays off.
        enbl_next = 1'b0;
      end
    end

    // re-arm starts over from an idle packetizer with a cleared counter.
    if (arm)
    begin
      cntr_next = '0;
      enbl_next = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/pkt_acq_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module pkt_acq_top
(
  input  wire logic                aclk,
  input  wire logic                aresetn,
  input  wire pkt_pkg::reg_wr_t    reg_wr,
  input  wire pkt_pkg::reg_addr_t  rd_addr,
  output logic [31:0]              rd_data,
  input  wire pkt_pkg::sample_t    s_tdata,
  input  wire logic                s_tvalid,
  output logic                     s_tready,
  output pkt_pkg::axis_beat_t      m_beat,
  output logic                     m_tvalid,
  input  wire logic                m_tready
);

  import pkt_pkg::*;

  pkt_cfg_t cfg;
  logic     arm;
  logic     pkt_done;
  sample_t  f_tdata;
  logic     f_tvalid;
  logic     f_tready;

  pkt_cfg_regs u_regs
  (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .reg_wr   (reg_wr),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .pkt_done (pkt_done),
    .cfg      (cfg),
    .arm      (arm)
  );

  axis_sample_fifo u_fifo
  (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .s_tdata  (s_tdata),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .m_tdata  (f_tdata),
    .m_tvalid (f_tvalid),
    .m_tready (f_tready)
  );

  axis_packetizer u_pack
  (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .cfg      (cfg),
    .arm      (arm),
    .s_tdata  (f_tdata),
    .s_tvalid (f_tvalid),
    .s_tready (f_tready),
    .m_beat   (m_beat),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .pkt_done (pkt_done)
  );

endmodule

`default_nettype wire

// ==== bench/tb_pkt_acq.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_pkt_acq;

  import pkt_pkg::*;

  // the tests together take about this many clock cycles.
  localparam int test_cycles = 650;

  logic        aclk;
  logic        aresetn;
  reg_wr_t     reg_wr;
  reg_addr_t   rd_addr;
  logic [31:0] rd_data;
  sample_t     s_tdata;
  logic        s_tvalid;
  logic        s_tready;
  axis_beat_t  m_beat;
  logic        m_tvalid;
  logic        m_tready;

  // the source and sink modes are 0 for off, 1 for always and 2 for random.
  int          src_mode;
  int          snk_mode;
  logic [31:0] lcg_state;
  logic [31:0] rnd;
  logic        src_taken;

  // scoreboard and a small model of the packet framing.
  sample_t     sb [$];
  sample_t     exp_data;
  sample_t     last_out_data;
  sample_t     first_sample;
  pkt_len_t    len_m;
  pkt_len_t    beat_idx;
  logic        cont_m;
  logic        drain_m;
  logic        done_m;
  int          beats_out;
  int          errors;
  int          tests_run;
  int          tests_bad;

  pkt_acq_top UUT
  (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .reg_wr   (reg_wr),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .s_tdata  (s_tdata),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .m_beat   (m_beat),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready)
  );

  always #5 aclk = ~aclk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge aclk);
      #1;
    end
  endtask

  task automatic reg_write(input reg_addr_t addr, input logic [31:0] data);
    reg_wr = '{en: 1'b1, addr: addr, data: data};
    @(posedge aclk);
    #1;
    reg_wr = '0;
  endtask

  task automatic reg_read(input reg_addr_t addr, output logic [31:0] data);
    rd_addr = addr;
    @(posedge aclk);
    #1;
    data = rd_data;
  endtask

  task automatic wait_beats(input int n, input int limit);
    int target;
    int cyc;
    target = beats_out + n;
    cyc = 0;
    while (beats_out < target && cyc < limit)
    begin
      idle(1);
      cyc++;
    end
    if (beats_out < target)
    begin
      errors++;
      $display("timed out after %0d cycles waiting for %0d output beats", limit, n);
    end
  endtask

  // waits until every accepted sample has left or until one is queued.
  task automatic wait_queue(input bit want_empty, input int limit);
    int cyc;
    cyc = 0;
    while (((want_empty && (sb.size() != 0 || s_tvalid)) ||
            (!want_empty && sb.size() == 0)) && cyc < limit)
    begin
      idle(1);
      cyc++;
    end
    if ((want_empty && (sb.size() != 0 || s_tvalid)) ||
        (!want_empty && sb.size() == 0))
    begin
      errors++;
      $display("timed out after %0d cycles waiting on the scoreboard queue", limit);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before)
      $display("[%0t] %s: ok", $time, name);
    else
    begin
      tests_bad++;
      $display("[%0t] %s: %0d errors", $time, name, errors - errs_before);
    end
  endtask

  // the source holds a beat until it is taken while the sink may change at any edge.
  always @(posedge aclk)
  begin
    src_taken = s_tvalid && s_tready;
    #1;
    rnd = lcg_next();
    if (!s_tvalid || src_taken)
    begin
      if (src_mode == 2)
        s_tvalid = (rnd[31:30] != 2'b00);
      else
        s_tvalid = (src_mode == 1);
      s_tdata = lcg_next();
    end
    if (snk_mode == 2)
      m_tready = rnd[20];
    else
      m_tready = (snk_mode == 1);
  end

  always @(posedge aclk)
  begin
    if (aresetn)
    begin
      if (!s_tready && !drain_m)
      begin
        assert (sb.size() == 8)
        else
        begin
          errors++;
          $display("Fail s_tready: %h with %h samples held, expected 8", s_tready, sb.size());
        end
      end
      if (drain_m && done_m)
        check_value("s_tready", {31'd0, s_tready}, 32'h1);
      if (done_m)
        check_value("m_tvalid", {31'd0, m_tvalid}, 32'h0);

      if (m_tvalid && m_tready)
      begin
        if (sb.size() == 0)
        begin
          errors++;
          $display("an output beat left with no accepted sample waiting for it");
        end
        else
        begin
          exp_data = sb.pop_front();
          check_value("m_beat.data", m_beat.data, exp_data);
        end
        check_value("m_beat.last", {31'd0, m_beat.last}, {31'd0, beat_idx == len_m});
        last_out_data = m_beat.data;
        beats_out++;
        if (beat_idx == len_m)
        begin
          beat_idx = '0;
          done_m   = !cont_m;
        end
        else
          beat_idx = beat_idx + 16'd1;
      end

      if (s_tvalid && s_tready)
        sb.push_back(s_tdata);

      if (reg_wr.en && reg_wr.addr == reg_addr_len)
      begin
        len_m    = reg_wr.data[cntr_w-1:0];
        beat_idx = '0;
        done_m   = 1'b0;
      end
      if (reg_wr.en && reg_wr.addr == reg_addr_ctrl)
      begin
        cont_m  = reg_wr.data[0];
        drain_m = reg_wr.data[1];
      end
    end
  end

  // a beat that is held back must not change until it is taken.
  stall_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_beat)))
  else
  begin
    errors++;
    $display("Fail m_beat: stalled beat changed to %h", m_beat);
  end

  initial
  begin
    repeat (test_cycles * 4) @(posedge aclk);
    $display("watchdog: the run did not finish within %0d cycles", test_cycles * 4);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    int          errs0;
    logic [31:0] rdv;

    aclk      = 1'b0;
    aresetn   = 1'b0;
    reg_wr    = '0;
    rd_addr   = '0;
    s_tdata   = '0;
    s_tvalid  = 1'b0;
    m_tready  = 1'b0;
    src_mode  = 0;
    snk_mode  = 0;
    lcg_state = 32'd85421;
    len_m     = '0;
    beat_idx  = '0;
    cont_m    = 1'b0;
    drain_m   = 1'b0;
    done_m    = 1'b1;
    beats_out = 0;
    errors    = 0;
    tests_run = 0;
    tests_bad = 0;

    repeat (5) @(posedge aclk);
    #1;
    aresetn = 1'b1;

    errs0 = errors;
    check_value("m_tvalid", {31'd0, m_tvalid}, 32'h0);
    check_value("s_tready", {31'd0, s_tready}, 32'h1);
    reg_read(reg_addr_count, rdv);
    check_value("rd_data", rdv, 32'h0);
    finish_test("reset state", errs0);

    errs0 = errors;
    src_mode = 1;
    snk_mode = 1;
    reg_write(reg_addr_len, 32'd4);
    wait_beats(5, 40);
    idle(20);
    finish_test("one-shot", errs0);

    errs0 = errors;
    reg_write(reg_addr_len, 32'd2);
    wait_beats(3, 40);
    idle(4);
    reg_read(reg_addr_count, rdv);
    check_value("rd_data", rdv, 32'h2);
    finish_test("re-arm", errs0);

    errs0 = errors;
    reg_write(reg_addr_ctrl, 32'h1);
    reg_write(reg_addr_len, 32'd3);
    wait_beats(40, 80);
    finish_test("continuous", errs0);

    errs0 = errors;
    src_mode = 2;
    snk_mode = 2;
    idle(300);
    src_mode = 0;
    snk_mode = 1;
    wait_queue(1'b1, 100);
    finish_test("back-pressure", errs0);

    errs0 = errors;
    reg_write(reg_addr_ctrl, 32'h0);
    reg_write(reg_addr_len, 32'd3);
    src_mode = 1;
    wait_beats(4, 40);
    idle(12);
    reg_write(reg_addr_ctrl, 32'h2);
    idle(20);
    src_mode = 0;
    // a full FIFO empties one entry per cycle once the input stops.
    idle(12);
    $display("drain discarded %0d samples", sb.size());
    sb.delete();
    reg_write(reg_addr_ctrl, 32'h0);
    reg_write(reg_addr_len, 32'd2);
    src_mode = 1;
    wait_queue(1'b0, 20);
    first_sample = sb[0];
    wait_beats(1, 20);
    check_value("m_beat.data", last_out_data, first_sample);
    wait_beats(2, 20);
    idle(5);
    src_mode = 0;
    finish_test("drain", errs0);

    $display("tests run %0d, tests with errors %0d, errors %0d", tests_run, tests_bad, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
src/pkt_pkg.sv
src/pkt_cfg_regs.sv
src/axis_sample_fifo.sv
src/axis_packetizer.sv
src/pkt_acq_top.sv
bench/tb_pkt_acq.sv

// ==== Makefile ====
# Verilator build and run for the packet acquisition testbench.

VERILATOR ?= verilator
TOP       ?= tb_pkt_acq
FILELIST  ?= list.f
MDIR      ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(MDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(MDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q '^Test passed$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(MDIR) $(LOG)
